// File: build.f
rtl/tinyrv_pkg.sv
rtl/inst_decoder.sv
rtl/regfile_scoreboard.sv
rtl/decode_issue.sv
rtl/alu_pipe.sv
rtl/mul_pipe.sv
rtl/complete_arbiter.sv
rtl/issue_core_top.sv
verif/issue_core_checker.sv
verif/issue_core_assert.sv
verif/issue_core_tb.sv

// File: verif/issue_core_tb.sv
/*
 * Testbench for the decode and issue subsystem
 * Random instruction stream with hazards, checker and timeout
 */

`timescale 1ns/100ps
`default_nettype none

module issue_core_tb import tinyrv_pkg::*; ();

  localparam int num_insts     = 400;
  localparam int p_mul_stages  = 3;
  localparam int timeout_limit = num_insts * (p_mul_stages + 10) + 200;

  logic      clk;
  logic      rst;
  logic      fetch_val;
  inst_t     fetch_inst;
  seq_t      fetch_seq;
  logic      fetch_rdy;
  logic      cmp_val;
  reg_addr_t cmp_waddr;
  word_t     cmp_wdata;
  seq_t      cmp_seq;

  int mismatch_count;
  int fault_count;
  int outstanding;
  int seed        = 32'h1a51_819e;
  int cycle_count = 0;

  issue_core_top #(
    .p_mul_stages (p_mul_stages)
  ) u_dut (
    .clk        (clk),
    .rst        (rst),
    .fetch_val  (fetch_val),
    .fetch_inst (fetch_inst),
    .fetch_seq  (fetch_seq),
    .fetch_rdy  (fetch_rdy),
    .cmp_val    (cmp_val),
    .cmp_waddr  (cmp_waddr),
    .cmp_wdata  (cmp_wdata),
    .cmp_seq    (cmp_seq)
  );

  issue_core_checker u_checker (
    .clk            (clk),
    .rst            (rst),
    .fetch_val      (fetch_val),
    .fetch_rdy      (fetch_rdy),
    .fetch_inst     (fetch_inst),
    .fetch_seq      (fetch_seq),
    .cmp_val        (cmp_val),
    .cmp_waddr      (cmp_waddr),
    .cmp_wdata      (cmp_wdata),
    .cmp_seq        (cmp_seq),
    .mismatch_count (mismatch_count),
    .fault_count    (fault_count),
    .outstanding    (outstanding)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // --------------------
  // Stimulus helpers
  // --------------------

  function automatic int pick_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  // Mostly x0 to x7 so that hazards are frequent
  function automatic reg_addr_t pick_reg();
    if (pick_below(8) != 0) begin
      return reg_addr_t'(pick_below(8));
    end
    return reg_addr_t'(pick_below(32));
  endfunction

  // About 40% MUL, the rest split between R-type and I-type ALU ops
  function automatic inst_t make_inst();
    int          kind;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [11:0] imm;
    logic [2:0]  f3;
    kind = pick_below(100);
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    imm  = 12'(pick_below(4096));
    if (kind < 40) begin
      return {7'b0000001, rs2, rs1, 3'b000, rd, OPC_OP};
    end else if (kind < 75) begin
      case (pick_below(6))
        0:       return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP};
        1:       return {7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP};
        2:       return {7'b0000000, rs2, rs1, 3'b111, rd, OPC_OP};
        3:       return {7'b0000000, rs2, rs1, 3'b110, rd, OPC_OP};
        4:       return {7'b0000000, rs2, rs1, 3'b100, rd, OPC_OP};
        default: return {7'b0000000, rs2, rs1, 3'b010, rd, OPC_OP};
      endcase
    end
    case (pick_below(4))
      0:       f3 = 3'b000;
      1:       f3 = 3'b111;
      2:       f3 = 3'b110;
      default: f3 = 3'b100;
    endcase
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  // --------------------
  // Timeout
  // --------------------

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout after %0d cycles with %0d completions still missing",
               cycle_count, outstanding);
      $display("Some tests failed");
      $finish;
    end
  end

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    int idle;
    int assert_fails;
    int total;
    rst        = 1'b1;
    fetch_val  = 1'b0;
    fetch_inst = '0;
    fetch_seq  = '0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    // Quiet gap so an early completion would show up
    repeat (4) begin
      @(posedge clk);
      #1;
    end
    for (int i = 0; i < num_insts; i++) begin
      fetch_val  = 1'b1;
      fetch_inst = make_inst();
      @(posedge clk);
      while (!fetch_rdy) begin
        @(posedge clk);
      end
      #1;
      fetch_val = 1'b0;
      fetch_seq = fetch_seq + 1'b1;
      idle      = pick_below(4);
      repeat (idle) begin
        @(posedge clk);
        #1;
      end
    end
    // Drain, then a few more cycles to catch stray completions
    while (outstanding != 0) begin
      @(posedge clk);
      #1;
    end
    repeat (10) begin
      @(posedge clk);
      #1;
    end
    assert_fails = u_dut.u_assert.fail_count;
    total        = mismatch_count + fault_count + assert_fails + outstanding;
    $display("Errors: %0d mismatches, %0d protocol, %0d assertion, %0d missing completions",
             mismatch_count, fault_count, assert_fails, outstanding);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/issue_core_assert.sv
/*
 * Concurrent assertions bound to the issue core top level
 * Fetch stability, reset quiet bus, round-robin grant, no illegal in decode
 */

`timescale 1ns/100ps
`default_nettype none

module issue_core_assert import tinyrv_pkg::*; (
  input logic  clk,
  input logic  rst,
  input logic  fetch_val,
  input logic  fetch_rdy,
  input inst_t fetch_inst,
  input seq_t  fetch_seq,
  input logic  cmp_val,
  input logic  alu_req,
  input logic  mul_req,
  input logic  alu_grant,
  input logic  mul_grant,
  input logic  dec_val,
  input logic  dec_legal
);

  // Number of failed assertions
  int fail_count = 0;

  // Stalled fetch keeps its payload
  fetch_stable: assert property (@(posedge clk) disable iff (rst)
    fetch_val && !fetch_rdy |=> fetch_val && $stable(fetch_inst) && $stable(fetch_seq))
    else begin
      fail_count++;
      $error("fetch payload changed while stalled");
    end

  // From the second reset cycle the registers are known
  reset_quiet: assert property (@(posedge clk) rst && $past(rst) |-> !cmp_val)
    else begin
      fail_count++;
      $error("cmp_val high during reset");
    end

  // Tie grants one pipe and hands the next cycle to the other
  one_grant: assert property (@(posedge clk) disable iff (rst)
    alu_req && mul_req |=> $onehot({$past(alu_grant), $past(mul_grant)})
      && (alu_grant != $past(alu_grant)))
    else begin
      fail_count++;
      $error("tie on the completion bus not resolved one grant at a time in turn");
    end

  legal_decode: assert property (@(posedge clk) disable iff (rst) dec_val |-> dec_legal)
    else begin
      fail_count++;
      $error("decode register holds an illegal instruction");
    end

endmodule

bind issue_core_top issue_core_assert u_assert (
  .clk        (clk),
  .rst        (rst),
  .fetch_val  (fetch_val),
  .fetch_rdy  (fetch_rdy),
  .fetch_inst (fetch_inst),
  .fetch_seq  (fetch_seq),
  .cmp_val    (cmp_val),
  .alu_req    (alu_req),
  .mul_req    (mul_req),
  .alu_grant  (alu_grant),
  .mul_grant  (mul_grant),
  .dec_val    (u_decode.dec_val),
  .dec_legal  (u_decode.dec_legal)
);

`default_nettype wire

// File: verif/issue_core_checker.sv
/*
 * Scoreboard checker for the decode and issue subsystem
 * Keeps a program-order register model, predicts each result at fetch
 * and compares it with the completion bus by sequence number
 */

`timescale 1ns/100ps
`default_nettype none

module issue_core_checker import tinyrv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      fetch_val,
  input  logic      fetch_rdy,
  input  inst_t     fetch_inst,
  input  seq_t      fetch_seq,
  input  logic      cmp_val,
  input  reg_addr_t cmp_waddr,
  input  word_t     cmp_wdata,
  input  seq_t      cmp_seq,
  output int        mismatch_count,
  output int        fault_count,
  output int        outstanding
);

  // Architectural state in program order, x0 never written
  word_t     model_regs [32];

  // Expected completions indexed by seq
  logic      exp_live  [256];
  reg_addr_t exp_waddr [256];
  word_t     exp_wdata [256];

  // --------------------
  // Reference model
  // --------------------

  // Returns 0 for anything outside the subset
  function automatic bit model_execute(input inst_t inst, output word_t result);
    word_t      a;
    word_t      b;
    word_t      imm;
    logic [6:0] f7;
    logic [2:0] f3;
    a      = model_regs[inst[19:15]];
    b      = model_regs[inst[24:20]];
    imm    = {{20{inst[31]}}, inst[31:20]};
    f7     = inst[31:25];
    f3     = inst[14:12];
    result = '0;
    if (inst[6:0] == OPC_OP_IMM) begin
      case (f3)
        3'b000:  result = a + imm;
        3'b111:  result = a & imm;
        3'b110:  result = a | imm;
        3'b100:  result = a ^ imm;
        default: return 1'b0;
      endcase
      return 1'b1;
    end
    if (inst[6:0] != OPC_OP) begin
      return 1'b0;
    end
    case ({f7, f3})
      {7'b0000000, 3'b000}: result = a + b;
      {7'b0100000, 3'b000}: result = a - b;
      {7'b0000000, 3'b111}: result = a & b;
      {7'b0000000, 3'b110}: result = a | b;
      {7'b0000000, 3'b100}: result = a ^ b;
      {7'b0000000, 3'b010}: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      // Low half of the product
      {7'b0000001, 3'b000}: result = a * b;
      default:              return 1'b0;
    endcase
    return 1'b1;
  endfunction

  task automatic record_fetch();
    word_t     result;
    reg_addr_t rd;
    rd = fetch_inst[11:7];
    if (!model_execute(fetch_inst, result)) begin
      $display("Accepted instruction %h for seq %h is outside the subset",
               fetch_inst, fetch_seq);
      fault_count++;
      return;
    end
    if (exp_live[fetch_seq]) begin
      $display("Seq %h accepted again while still outstanding", fetch_seq);
      fault_count++;
    end else begin
      outstanding++;
    end
    exp_live[fetch_seq]  = 1'b1;
    exp_waddr[fetch_seq] = rd;
    exp_wdata[fetch_seq] = result;
    // x0 completes with data but keeps reading zero
    if (rd != '0) begin
      model_regs[rd] = result;
    end
  endtask

  // --------------------
  // Completion compare
  // --------------------

  task automatic check_completion();
    if (!exp_live[cmp_seq]) begin
      $display("Completion for seq %h arrived with no outstanding instruction of that seq",
               cmp_seq);
      fault_count++;
      return;
    end
    if (cmp_waddr !== exp_waddr[cmp_seq]) begin
      $display("MISMATCH cmp_waddr seq %h: expected %h, got %h",
               cmp_seq, exp_waddr[cmp_seq], cmp_waddr);
      mismatch_count++;
    end
    if (cmp_wdata !== exp_wdata[cmp_seq]) begin
      $display("MISMATCH cmp_wdata seq %h: expected %h, got %h",
               cmp_seq, exp_wdata[cmp_seq], cmp_wdata);
      mismatch_count++;
    end
    exp_live[cmp_seq] = 1'b0;
    outstanding--;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
      end
      for (int i = 0; i < 256; i++) begin
        exp_live[i] = 1'b0;
      end
      mismatch_count = 0;
      fault_count    = 0;
      outstanding    = 0;
    end else begin
      // A completion never belongs to the instruction fetched at this edge
      if (cmp_val) begin
        check_completion();
      end
      if (fetch_val && fetch_rdy) begin
        record_fetch();
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/issue_core_top.sv
/*
 * Decode and issue subsystem top level
 * Decode, scoreboard, ALU and multiply pipes, completion arbiter
 */

`timescale 1ns/100ps
`default_nettype none

module issue_core_top import tinyrv_pkg::*; #(
  parameter int p_mul_stages = 3
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      fetch_val,
  input  inst_t     fetch_inst,
  input  seq_t      fetch_seq,
  output logic      fetch_rdy,
  output logic      cmp_val,
  output reg_addr_t cmp_waddr,
  output word_t     cmp_wdata,
  output seq_t      cmp_seq
);

  // Decode to scoreboard
  reg_addr_t raddr0;
  reg_addr_t raddr1;
  reg_addr_t set_addr;
  word_t     rdata0;
  word_t     rdata1;
  logic      pending0;
  logic      pending1;
  logic      pending_dst;
  logic      set_val;

  // Decode to pipes
  logic      alu_val;
  logic      alu_rdy;
  logic      mul_val;
  logic      mul_rdy;
  word_t     op1;
  word_t     op2;
  uop_t      uop;
  reg_addr_t waddr;
  seq_t      seq;

  // Pipes to arbiter
  logic      alu_req;
  logic      alu_grant;
  reg_addr_t alu_waddr;
  word_t     alu_wdata;
  seq_t      alu_seq;
  logic      mul_req;
  logic      mul_grant;
  reg_addr_t mul_waddr;
  word_t     mul_wdata;
  seq_t      mul_seq;

  decode_issue u_decode (
    .clk         (clk),
    .rst         (rst),
    .fetch_val   (fetch_val),
    .fetch_inst  (fetch_inst),
    .fetch_seq   (fetch_seq),
    .fetch_rdy   (fetch_rdy),
    .raddr0      (raddr0),
    .raddr1      (raddr1),
    .rdata0      (rdata0),
    .rdata1      (rdata1),
    .pending0    (pending0),
    .pending1    (pending1),
    .pending_dst (pending_dst),
    .set_addr    (set_addr),
    .set_val     (set_val),
    .alu_val     (alu_val),
    .alu_rdy     (alu_rdy),
    .mul_val     (mul_val),
    .mul_rdy     (mul_rdy),
    .op1         (op1),
    .op2         (op2),
    .uop         (uop),
    .waddr       (waddr),
    .seq         (seq)
  );

  regfile_scoreboard u_regfile (
    .clk         (clk),
    .rst         (rst),
    .raddr0      (raddr0),
    .raddr1      (raddr1),
    .set_addr    (set_addr),
    .set_val     (set_val),
    .cmp_val     (cmp_val),
    .cmp_waddr   (cmp_waddr),
    .cmp_wdata   (cmp_wdata),
    .rdata0      (rdata0),
    .rdata1      (rdata1),
    .pending0    (pending0),
    .pending1    (pending1),
    .pending_dst (pending_dst)
  );

  alu_pipe u_alu (
    .clk       (clk),
    .rst       (rst),
    .val       (alu_val),
    .rdy       (alu_rdy),
    .uop       (uop),
    .op1       (op1),
    .op2       (op2),
    .waddr     (waddr),
    .seq       (seq),
    .grant     (alu_grant),
    .req       (alu_req),
    .req_waddr (alu_waddr),
    .req_wdata (alu_wdata),
    .req_seq   (alu_seq)
  );

  mul_pipe #(
    .p_mul_stages (p_mul_stages)
  ) u_mul (
    .clk       (clk),
    .rst       (rst),
    .val       (mul_val),
    .rdy       (mul_rdy),
    .op1       (op1),
    .op2       (op2),
    .waddr     (waddr),
    .seq       (seq),
    .grant     (mul_grant),
    .req       (mul_req),
    .req_waddr (mul_waddr),
    .req_wdata (mul_wdata),
    .req_seq   (mul_seq)
  );

  complete_arbiter u_arbiter (
    .clk       (clk),
    .rst       (rst),
    .alu_req   (alu_req),
    .alu_waddr (alu_waddr),
    .alu_wdata (alu_wdata),
    .alu_seq   (alu_seq),
    .mul_req   (mul_req),
    .mul_waddr (mul_waddr),
    .mul_wdata (mul_wdata),
    .mul_seq   (mul_seq),
    .alu_grant (alu_grant),
    .mul_grant (mul_grant),
    .cmp_val   (cmp_val),
    .cmp_waddr (cmp_waddr),
    .cmp_wdata (cmp_wdata),
    .cmp_seq   (cmp_seq)
  );

endmodule

`default_nettype wire

// File: rtl/complete_arbiter.sv
/*
 * Round-robin arbiter for the shared completion bus
 * One grant per cycle, winner muxed onto the bus in the same cycle
 */

`timescale 1ns/100ps
`default_nettype none

module complete_arbiter import tinyrv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      alu_req,
  input  reg_addr_t alu_waddr,
  input  word_t     alu_wdata,
  input  seq_t      alu_seq,
  input  logic      mul_req,
  input  reg_addr_t mul_waddr,
  input  word_t     mul_wdata,
  input  seq_t      mul_seq,
  output logic      alu_grant,
  output logic      mul_grant,
  output logic      cmp_val,
  output reg_addr_t cmp_waddr,
  output word_t     cmp_wdata,
  output seq_t      cmp_seq
);

  // Set when the ALU won the last granted cycle
  logic last_alu;

  // On a tie the pipe that lost last time goes first
  assign alu_grant = alu_req & (~mul_req | ~last_alu);
  assign mul_grant = mul_req & ~alu_grant;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_alu <= 1'b0;
    end else if (alu_grant || mul_grant) begin
      last_alu <= alu_grant;
    end
  end

  // Completion bus
  assign cmp_val   = alu_grant | mul_grant;
  assign cmp_waddr = mul_grant ? mul_waddr : alu_waddr;
  assign cmp_wdata = mul_grant ? mul_wdata : alu_wdata;
  assign cmp_seq   = mul_grant ? mul_seq   : alu_seq;

endmodule

`default_nettype wire

// File: rtl/mul_pipe.sv
/*
 * Multiply pipe of p_mul_stages stages, low 32 bits of the product
 * Whole pipeline freezes while the last stage waits for a grant
 */

`timescale 1ns/100ps
`default_nettype none

module mul_pipe import tinyrv_pkg::*; #(
  parameter int p_mul_stages = 3
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      val,
  output logic      rdy,
  input  word_t     op1,
  input  word_t     op2,
  input  reg_addr_t waddr,
  input  seq_t      seq,
  input  logic      grant,
  output logic      req,
  output reg_addr_t req_waddr,
  output word_t     req_wdata,
  output seq_t      req_seq
);

  localparam int last = p_mul_stages - 1;

  logic      stage_val   [p_mul_stages];
  reg_addr_t stage_waddr [p_mul_stages];
  word_t     stage_wdata [p_mul_stages];
  seq_t      stage_seq   [p_mul_stages];

  // Last stage full and not taken
  logic freeze;

  assign freeze = stage_val[last] & ~grant;
  assign rdy    = ~freeze;

  // --------------------
  // Valid tags
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < p_mul_stages; i++) begin
        stage_val[i] <= 1'b0;
      end
    end else if (!freeze) begin
      stage_val[0] <= val;
      for (int i = 1; i < p_mul_stages; i++) begin
        stage_val[i] <= stage_val[i-1];
      end
    end
  end

  // --------------------
  // Payload shift
  // --------------------

  // Product formed on entry, then carried down
  always_ff @(posedge clk) begin
    if (!freeze) begin
      stage_waddr[0] <= waddr;
      stage_wdata[0] <= op1 * op2;
      stage_seq[0]   <= seq;
      for (int i = 1; i < p_mul_stages; i++) begin
        stage_waddr[i] <= stage_waddr[i-1];
        stage_wdata[i] <= stage_wdata[i-1];
        stage_seq[i]   <= stage_seq[i-1];
      end
    end
  end

  assign req       = stage_val[last];
  assign req_waddr = stage_waddr[last];
  assign req_wdata = stage_wdata[last];
  assign req_seq   = stage_seq[last];

endmodule

`default_nettype wire

// File: rtl/alu_pipe.sv
/*
 * Single-cycle ALU pipe
 * Result held in an output register until the completion bus grants it
 */

`timescale 1ns/100ps
`default_nettype none

module alu_pipe import tinyrv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      val,
  output logic      rdy,
  input  uop_t      uop,
  input  word_t     op1,
  input  word_t     op2,
  input  reg_addr_t waddr,
  input  seq_t      seq,
  input  logic      grant,
  output logic      req,
  output reg_addr_t req_waddr,
  output word_t     req_wdata,
  output seq_t      req_seq
);

  word_t result;

  always_comb begin
    case (uop)
      uop_add: result = op1 + op2;
      uop_sub: result = op1 - op2;
      uop_and: result = op1 & op2;
      uop_or:  result = op1 | op2;
      uop_xor: result = op1 ^ op2;
      // Signed compare, 0 or 1
      uop_slt: result = {31'b0, $signed(op1) < $signed(op2)};
      // MUL never routed here
      default: result = '0;
    endcase
  end

  // Output register, empty or leaving this cycle takes a new one
  logic out_val;

  assign rdy = ~out_val | grant;
  assign req = out_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_val <= 1'b0;
    end else if (val && rdy) begin
      out_val <= 1'b1;
    end else if (grant) begin
      out_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (val && rdy) begin
      req_waddr <= waddr;
      req_wdata <= result;
      req_seq   <= seq;
    end
  end

endmodule

`default_nettype wire

// File: rtl/decode_issue.sv
/*
 * Decode and issue stage
 * Registers the fetched instruction, stalls on pending registers
 * and issues to the ALU or multiply pipe with valid/ready
 */

`timescale 1ns/100ps
`default_nettype none

module decode_issue import tinyrv_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  // Fetch side
  input  logic      fetch_val,
  input  inst_t     fetch_inst,
  input  seq_t      fetch_seq,
  output logic      fetch_rdy,

  // Register file and scoreboard
  output reg_addr_t raddr0,
  output reg_addr_t raddr1,
  input  word_t     rdata0,
  input  word_t     rdata1,
  input  logic      pending0,
  input  logic      pending1,
  input  logic      pending_dst,
  output reg_addr_t set_addr,
  output logic      set_val,

  // Issue to the pipes
  output logic      alu_val,
  input  logic      alu_rdy,
  output logic      mul_val,
  input  logic      mul_rdy,
  output word_t     op1,
  output word_t     op2,
  output uop_t      uop,
  output reg_addr_t waddr,
  output seq_t      seq
);

  // --------------------
  // Decode register
  // --------------------

  logic  dec_val;
  inst_t dec_inst;
  seq_t  dec_seq;

  logic  fetch_xfer;
  logic  issue_xfer;

  assign fetch_xfer = fetch_val & fetch_rdy;

  // Only the valid tag is reset
  always_ff @(posedge clk) begin
    if (rst) begin
      dec_val <= 1'b0;
    end else if (fetch_xfer) begin
      dec_val <= 1'b1;
    end else if (issue_xfer) begin
      dec_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_xfer) begin
      dec_inst <= fetch_inst;
      dec_seq  <= fetch_seq;
    end
  end

  // --------------------
  // Decode
  // --------------------

  logic      dec_legal;
  pipe_sel_t dec_pipe;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  reg_addr_t dec_rd;
  logic      dec_use_imm;
  word_t     dec_imm;

  inst_decoder u_decoder (
    .inst    (dec_inst),
    .legal   (dec_legal),
    .uop     (uop),
    .pipe    (dec_pipe),
    .rs1     (dec_rs1),
    .rs2     (dec_rs2),
    .rd      (dec_rd),
    .use_imm (dec_use_imm),
    .imm     (dec_imm)
  );

  assign raddr0   = dec_rs1;
  assign raddr1   = dec_rs2;
  assign set_addr = dec_rd;

  // Hazards: RAW on either source, WAW on the destination
  // Illegal encodings park here for good
  logic stall;
  logic can_issue;

  assign stall     = pending0 | pending1 | pending_dst | ~dec_legal;
  assign can_issue = dec_val & ~stall;

  // --------------------
  // Issue
  // --------------------

  // Single valid steered by the decoded pipe
  assign alu_val = can_issue & (dec_pipe == pipe_alu);
  assign mul_val = can_issue & (dec_pipe == pipe_mul);

  assign issue_xfer = (alu_val & alu_rdy) | (mul_val & mul_rdy);

  // Destination goes pending on the issue edge
  assign set_val = issue_xfer;

  // Room when empty or leaving this cycle
  assign fetch_rdy = ~dec_val | issue_xfer;

  // Shared payload to both pipes
  assign op1   = rdata0;
  assign op2   = dec_use_imm ? dec_imm : rdata1;
  assign waddr = dec_rd;
  assign seq   = dec_seq;

endmodule

`default_nettype wire

// File: rtl/regfile_scoreboard.sv
/*
 * 32 x 32 register file with a pending bit per register
 * Two read ports, completion write port, pending-set port at issue
 */

`timescale 1ns/100ps
`default_nettype none

module regfile_scoreboard import tinyrv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t raddr0,
  input  reg_addr_t raddr1,
  input  reg_addr_t set_addr,
  input  logic      set_val,
  input  logic      cmp_val,
  input  reg_addr_t cmp_waddr,
  input  word_t     cmp_wdata,
  output word_t     rdata0,
  output word_t     rdata1,
  output logic      pending0,
  output logic      pending1,
  output logic      pending_dst
);

  // x0 has no storage
  word_t       regs [1:31];
  logic [31:0] pending;

  // --------------------
  // Register storage
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (cmp_val && cmp_waddr != '0) begin
      regs[cmp_waddr] <= cmp_wdata;
    end
  end

  // No bypass, a write shows on the next cycle
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  // --------------------
  // Pending bits
  // --------------------

  // Set at issue, cleared at completion
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (cmp_val) begin
        pending[cmp_waddr] <= 1'b0;
      end
      // Later assignment, so a set in the same cycle wins
      // x0 is never marked
      if (set_val && set_addr != '0) begin
        pending[set_addr] <= 1'b1;
      end
    end
  end

  assign pending0    = pending[raddr0];
  assign pending1    = pending[raddr1];
  assign pending_dst = pending[set_addr];

endmodule

`default_nettype wire

// File: rtl/inst_decoder.sv
/*
 * Instruction decoder for the integer subset
 * Maps an instruction word to micro-op, register indices, immediate
 * and the execute pipe that takes it
 */

`timescale 1ns/100ps
`default_nettype none

module inst_decoder import tinyrv_pkg::*; (
  input  inst_t     inst,
  output logic      legal,
  output uop_t      uop,
  output pipe_sel_t pipe,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output logic      use_imm,
  output word_t     imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // Fields at fixed positions
  assign rs1 = inst[19:15];
  assign rd  = inst[11:7];
  // I-type immediate, sign-extended
  assign imm = {{20{inst[31]}}, inst[31:20]};

  always_comb begin
    legal   = 1'b0;
    uop     = uop_add;
    pipe    = pipe_alu;
    use_imm = 1'b0;
    rs2     = inst[24:20];
    if (opcode == OPC_OP) begin
      // Register-register forms, told apart by funct7 then funct3
      case ({funct7, funct3})
        {7'b0000000, 3'b000}: begin legal = 1'b1; uop = uop_add; end
        {7'b0100000, 3'b000}: begin legal = 1'b1; uop = uop_sub; end
        {7'b0000000, 3'b111}: begin legal = 1'b1; uop = uop_and; end
        {7'b0000000, 3'b110}: begin legal = 1'b1; uop = uop_or;  end
        {7'b0000000, 3'b100}: begin legal = 1'b1; uop = uop_xor; end
        {7'b0000000, 3'b010}: begin legal = 1'b1; uop = uop_slt; end
        {7'b0000001, 3'b000}: begin
          legal = 1'b1;
          uop   = uop_mul;
          pipe  = pipe_mul;
        end
        default: legal = 1'b0;
      endcase
    end else if (opcode == OPC_OP_IMM) begin
      // Only rs1 is read, x0 never stalls
      use_imm = 1'b1;
      rs2     = '0;
      case (funct3)
        3'b000:  begin legal = 1'b1; uop = uop_add; end
        3'b111:  begin legal = 1'b1; uop = uop_and; end
        3'b110:  begin legal = 1'b1; uop = uop_or;  end
        3'b100:  begin legal = 1'b1; uop = uop_xor; end
        // SLTI and the shifts are outside the subset
        default: legal = 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/tinyrv_pkg.sv
/*
 * Shared types for the tiny RISC-V decode and issue subsystem:
 * word and index widths, micro-ops, pipe select and opcodes
 */

`default_nettype none

package tinyrv_pkg;

  // --------------------
  // Widths with a meaning
  // --------------------

  // Operand, immediate and result data
  typedef logic [31:0] word_t;
  // Raw instruction word
  typedef logic [31:0] inst_t;
  // Architectural register index
  typedef logic [4:0]  reg_addr_t;
  // Tag that follows an instruction from fetch to completion
  typedef logic [7:0]  seq_t;

  // --------------------
  // Micro-ops
  // --------------------

  // Immediate forms share the register-register uop
  typedef enum logic [2:0] {
    uop_add,
    uop_sub,
    uop_and,
    uop_or,
    uop_xor,
    uop_slt,
    uop_mul
  } uop_t;

  // Execute pipe an instruction is routed to
  typedef enum logic {
    pipe_alu,
    pipe_mul
  } pipe_sel_t;

  // Major opcodes of the subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

endpackage

`default_nettype wire
